// ==== Makefile ====
SIM      ?= verilator
TOP      ?= tb_lsu
FILELIST ?= vlog.f
FLAGS    ?= --binary --timing --assert
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/lsu_properties.sv ====
`timescale 1ns/1ps

module lsu_properties #(
  parameter int MAX_OUTSTANDING = lsu_pkg::MAX_OUTSTANDING_DEF
) (
  input logic                                   clk,
  input logic                                   rst_n,
  input logic                                   data_req_i,
  input logic                                   data_gnt_i,
  input logic                                   data_rvalid_i,
  input lsu_pkg::lsu_ctrl_t                     ctrl_i,
  input logic [$clog2(MAX_OUTSTANDING + 1)-1:0] cnt_i
);

  ////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////

  // Request and its control info wait for the grant
  req_holds: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(ctrl_i))
    else $error("data request dropped or changed before its grant");

  // Never more in flight than the configured depth
  cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_i <= MAX_OUTSTANDING)
    else $error("outstanding count above the limit");

  // Every read-valid belongs to a granted transaction
  rvalid_owned: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> cnt_i != '0)
    else $error("read-valid with no transaction outstanding");

endmodule

// ==== dv/tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu;

  localparam int MAX_OUT     = lsu_pkg::MAX_OUTSTANDING_DEF;
  localparam int NUM_ACC     = 400;
  localparam int CYCLE_LIMIT = 40 * NUM_ACC;
  localparam int MEM_WORDS   = 64;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  logic               req_ready;
  logic [31:0]        op_a;
  logic [31:0]        op_b;
  logic               req_we;
  lsu_pkg::lsu_size_e req_size;
  logic               req_sext;
  logic [31:0]        req_wdata;
  logic               data_req;
  logic               data_gnt;
  logic [31:0]        data_addr;
  logic               data_we;
  logic [3:0]         data_be;
  logic [31:0]        data_wdata;
  logic               data_rvalid;
  logic [31:0]        data_rdata;
  logic               resp_valid;
  logic [31:0]        resp_rdata;

  // Bus side memory and the reference copy
  logic [31:0] bus_mem [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  // Pending read-valids in grant order
  int          rv_due [$];
  logic [31:0] rv_data [$];
  int          last_due;
  // Expected results in access order
  logic [31:0] exp_data [$];
  bit          exp_load [$];

  integer             seed;
  int                 cyc;
  int                 inflight;
  int                 issued;
  int                 done_cnt;
  int                 parts;
  int                 val_errs;
  int                 other_errs;
  bit                 have_req;
  bit                 finished;
  bit                 timed_out;
  logic [31:0]        acc_addr;
  bit                 last_store;
  logic [7:0]         last_addr;
  lsu_pkg::lsu_size_e last_size;

  lsu_top #(
    .MAX_OUTSTANDING (MAX_OUT)
  ) dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .req_we_i      (req_we),
    .req_size_i    (req_size),
    .req_sext_i    (req_sext),
    .req_wdata_i   (req_wdata),
    .data_req_o    (data_req),
    .data_gnt_i    (data_gnt),
    .data_addr_o   (data_addr),
    .data_we_o     (data_we),
    .data_be_o     (data_be),
    .data_wdata_o  (data_wdata),
    .data_rvalid_i (data_rvalid),
    .data_rdata_i  (data_rdata),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata)
  );

  bind lsu_txn_ctrl lsu_properties #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_req_i    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .ctrl_i        (ctrl_i),
    .cnt_i         (cnt_q)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic int size_bytes(input lsu_pkg::lsu_size_e s);
    case (s)
      lsu_pkg::LSU_WORD: return 4;
      lsu_pkg::LSU_HALF: return 2;
      default:           return 1;
    endcase
  endfunction

  // Word crossing accesses need a second bus part
  function automatic bit expect_split(input lsu_pkg::lsu_size_e s, input logic [1:0] off);
    return (s == lsu_pkg::LSU_WORD && off != 2'b00) || (s == lsu_pkg::LSU_HALF && off == 2'b11);
  endfunction

  // Little-endian byte fetch
  function automatic logic [7:0] model_byte(input logic [7:0] a);
    return ref_mem[a[7:2]][{a[1:0], 3'b000} +: 8];
  endfunction

  task automatic model_access();
    int          nb;
    int          i;
    logic [7:0]  ba;
    logic [31:0] val;
    nb  = size_bytes(req_size);
    val = '0;
    for (i = 0; i < nb; i++) begin
      ba = acc_addr[7:0] + 8'(i);
      if (req_we) begin
        ref_mem[ba[7:2]][{ba[1:0], 3'b000} +: 8] = req_wdata[8*i +: 8];
      end else begin
        val[8*i +: 8] = model_byte(ba);
      end
    end
    // Sign fill above the loaded bytes
    if (req_sext && req_size == lsu_pkg::LSU_BYTE) val[31:8] = {24{val[7]}};
    if (req_sext && req_size == lsu_pkg::LSU_HALF) val[31:16] = {16{val[15]}};
    exp_data.push_back(val);
    exp_load.push_back(!req_we);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic pick_access();
    logic [31:0] r;
    logic [7:0]  a;
    r = $random(seed);
    // Half of the stores are read back at once
    if (last_store && r[0]) begin
      a        = last_addr;
      req_size = last_size;
      req_we   = 1'b0;
    end else begin
      a = r[15:8];
      // Keep the second word inside memory
      if (a > 8'd251) a = a - 8'd4;
      req_size = (r[3:2] == 2'b11) ? lsu_pkg::LSU_WORD : lsu_pkg::lsu_size_e'(r[3:2]);
      req_we   = r[4];
    end
    req_sext   = r[5];
    req_wdata  = $random(seed);
    op_a       = $random(seed);
    op_b       = {24'd0, a} - op_a;
    acc_addr   = {24'd0, a};
    last_store = req_we;
    last_addr  = a;
    last_size  = req_size;
    parts      = 0;
    issued++;
  endtask

  // Mostly back-to-back with idle gaps now and then
  task automatic drive_request();
    logic [31:0] r;
    if (!have_req) begin
      r = $random(seed);
      if (issued < NUM_ACC && r[1:0] != 2'b00) begin
        pick_access();
        have_req = 1'b1;
      end
    end
    req_valid = have_req;
  endtask

  task automatic drive_bus();
    logic [31:0] r;
    r           = $random(seed);
    data_gnt    = (r[1:0] != 2'b00);
    data_rvalid = 1'b0;
    data_rdata  = $random(seed);
    if (rv_due.size() > 0 && rv_due[0] <= cyc) begin
      data_rvalid = 1'b1;
      data_rdata  = rv_data.pop_front();
      void'(rv_due.pop_front());
    end
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_idle();
    assert (!data_req) else begin
      val_errs++;
      $display("[FAIL] t=%0t data_req_o expected 0 actual %b", $time, data_req);
    end
    assert (!req_ready) else begin
      val_errs++;
      $display("[FAIL] t=%0t req_ready_o expected 0 actual %b", $time, req_ready);
    end
    assert (!resp_valid) else begin
      val_errs++;
      $display("[FAIL] t=%0t resp_valid_o expected 0 actual %b", $time, resp_valid);
    end
  endtask

  task automatic sample_cycle();
    logic [31:0] r;
    logic [31:0] exp;
    logic [31:0] part_addr;
    logic [31:0] ba;
    logic [3:0]  exp_be;
    bit          is_load;
    int          due;
    int          b;
    int          nparts;
    // On a grant check the part fields, apply the write and schedule the read-valid
    if (data_req && data_gnt) begin
      part_addr = (parts == 0) ? acc_addr : ({acc_addr[31:2], 2'b00} + 32'd4);
      assert (data_addr == part_addr) else begin
        val_errs++;
        $display("[FAIL] t=%0t data_addr_o expected %08h actual %08h",
                 $time, part_addr, data_addr);
      end
      // Lanes of the access bytes that fall into this word
      exp_be = '0;
      for (b = 0; b < size_bytes(req_size); b++) begin
        ba = acc_addr + 32'(b);
        if (ba[31:2] == part_addr[31:2]) exp_be[ba[1:0]] = 1'b1;
      end
      assert (data_be == exp_be) else begin
        val_errs++;
        $display("[FAIL] t=%0t data_be_o expected %b actual %b", $time, exp_be, data_be);
      end
      assert (data_we == req_we) else begin
        val_errs++;
        $display("[FAIL] t=%0t data_we_o expected %b actual %b", $time, req_we, data_we);
      end
      for (b = 0; b < 4; b++) begin
        if (data_we && data_be[b]) bus_mem[data_addr[7:2]][8*b +: 8] = data_wdata[8*b +: 8];
      end
      r   = $random(seed);
      due = cyc + 1 + int'(r % 3);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rv_due.push_back(due);
      rv_data.push_back(bus_mem[data_addr[7:2]]);
      inflight++;
      parts++;
    end
    assert (!req_ready || (data_req && data_gnt)) else begin
      other_errs++;
      $display("req_ready_o rose without a bus grant at %0t", $time);
    end
    // Access consumed on its last part
    if (req_valid && req_ready) begin
      nparts = expect_split(req_size, acc_addr[1:0]) ? 2 : 1;
      assert (parts == nparts) else begin
        other_errs++;
        $display("Access at %08h took %0d bus parts instead of %0d", acc_addr, parts, nparts);
      end
      model_access();
      done_cnt++;
      have_req = 1'b0;
    end
    // A grant at a full count shows even when a read-valid frees a slot in the same cycle
    assert (inflight <= MAX_OUT) else begin
      other_errs++;
      $display("More than %0d transactions in flight at %0t", MAX_OUT, $time);
    end
    if (data_rvalid) inflight--;
    if (resp_valid) begin
      if (exp_data.size() == 0) begin
        other_errs++;
        $display("Result at %0t with no access waiting for one", $time);
      end else begin
        exp     = exp_data.pop_front();
        is_load = exp_load.pop_front();
        if (is_load) begin
          assert (resp_rdata == exp) else begin
            val_errs++;
            $display("[FAIL] t=%0t resp_rdata_o expected %08h actual %08h",
                     $time, exp, resp_rdata);
          end
        end
      end
    end
  endtask

  task automatic check_memories();
    int w;
    for (w = 0; w < MEM_WORDS; w++) begin
      assert (bus_mem[w] == ref_mem[w]) else begin
        val_errs++;
        $display("[FAIL] t=%0t bus_mem[%0d] expected %08h actual %08h",
                 $time, w, ref_mem[w], bus_mem[w]);
      end
    end
    assert (exp_data.size() == 0) else begin
      other_errs++;
      $display("%0d results never arrived", exp_data.size());
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    seed        = 58;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    op_a        = '0;
    op_b        = '0;
    req_we      = 1'b0;
    req_size    = lsu_pkg::LSU_BYTE;
    req_sext    = 1'b0;
    req_wdata   = '0;
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    last_due    = -1;
    acc_addr    = '0;
    last_store  = 1'b0;
    last_addr   = '0;
    last_size   = lsu_pkg::LSU_BYTE;
    for (int w = 0; w < MEM_WORDS; w++) begin
      bus_mem[w] = $random(seed);
      ref_mem[w] = bus_mem[w];
    end
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
    // Idle outputs out of reset before any access
    @(negedge clk);
    check_idle();
    while (!finished && !timed_out) begin
      @(posedge clk);
      #2;
      drive_bus();
      drive_request();
      @(negedge clk);
      sample_cycle();
      cyc++;
      if (done_cnt == NUM_ACC && !have_req && rv_due.size() == 0) begin
        finished = 1'b1;
      end else if (cyc >= CYCLE_LIMIT) begin
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      other_errs++;
      $display("Run stopped after %0d cycles with %0d of %0d accesses done",
               cyc, done_cnt, NUM_ACC);
    end else begin
      check_memories();
    end
    $display("Accesses %0d, value errors %0d, other errors %0d", done_cnt, val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  // Data and address width
  parameter int XLEN = 32;

  // One enable per byte lane
  parameter int BE_W = XLEN / 8;

  // Default number of transactions in flight on the data bus
  parameter int MAX_OUTSTANDING_DEF = 2;

  ////////////////////////////////////////
  // Access description
  ////////////////////////////////////////

  // Access size as encoded by the execute stage
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Control info kept per bus transaction until its read-valid
  typedef struct packed {
    // Size of the original access
    lsu_size_e  size;
    // Sign extension for loads
    logic       sext;
    // Store flag
    logic       we;
    // Byte offset of the original address
    logic [1:0] offset;
    // Low only for the first half of a split access
    logic       last;
  } lsu_ctrl_t;

endpackage

// ==== hw/lsu_rdata_align.sv ====
`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                     clk,
  input  logic                     rst_n,

  // Bus response and its control entry
  input  logic                     rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] rdata_i,
  input  lsu_pkg::lsu_ctrl_t       ctrl_i,

  // Result to write-back
  output logic                     resp_valid_o,
  output logic [lsu_pkg::XLEN-1:0] resp_rdata_o
);

  // Low word of a split load
  logic [lsu_pkg::XLEN-1:0]   rdata_q;
  // A first half is held and waits for its second
  logic                       half_q;
  // Two words side by side, then shifted down
  logic [2*lsu_pkg::XLEN-1:0] rdata_full;
  logic [2*lsu_pkg::XLEN-1:0] rdata_shift;

  ////////////////////////////////////////
  // First half capture
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_q <= 1'b0;
    end else if (rvalid_i) begin
      half_q <= !ctrl_i.last;
    end
  end

  // Store responses carry no useful data
  always_ff @(posedge clk) begin
    if (rvalid_i && !ctrl_i.last && !ctrl_i.we) begin
      rdata_q <= rdata_i;
    end
  end

  ////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////

  // Unsplit access wraps its own word around the shift
  assign rdata_full  = half_q ? {rdata_i, rdata_q} : {rdata_i, rdata_i};
  assign rdata_shift = rdata_full >> {ctrl_i.offset, 3'b000};

  always_comb begin
    case (ctrl_i.size)
      lsu_pkg::LSU_BYTE:
        resp_rdata_o = {{24{ctrl_i.sext && rdata_shift[7]}}, rdata_shift[7:0]};
      lsu_pkg::LSU_HALF:
        resp_rdata_o = {{16{ctrl_i.sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:
        resp_rdata_o = rdata_shift[lsu_pkg::XLEN-1:0];
    endcase
  end

  // One result per access, none for a first half
  assign resp_valid_o = rvalid_i && ctrl_i.last;

endmodule

// ==== hw/lsu_req_gen.sv ====
`timescale 1ns/1ps

module lsu_req_gen (
  input  logic                     clk,
  input  logic                     rst_n,

  // Access from the execute stage
  input  logic                     req_valid_i,
  input  logic [lsu_pkg::XLEN-1:0] op_a_i,
  input  logic [lsu_pkg::XLEN-1:0] op_b_i,
  input  logic                     req_we_i,
  input  lsu_pkg::lsu_size_e       req_size_i,
  input  logic                     req_sext_i,
  input  logic [lsu_pkg::XLEN-1:0] req_wdata_i,

  // Grant of the current part
  input  logic                     txn_accept_i,

  // Bus request fields
  output logic                     split_o,
  output logic [lsu_pkg::XLEN-1:0] addr_o,
  output logic                     we_o,
  output logic [lsu_pkg::BE_W-1:0] be_o,
  output logic [lsu_pkg::XLEN-1:0] wdata_o,
  output lsu_pkg::lsu_ctrl_t       ctrl_o
);

  // Effective address before word realignment
  logic [lsu_pkg::XLEN-1:0]   addr;
  // Byte position inside the word
  logic [1:0]                 offset;
  // High during the second part of a split access
  logic                       split_q;
  // Store data doubled and shifted, upper half is the rotation
  logic [2*lsu_pkg::XLEN-1:0] wdata_dbl;

  assign addr   = op_a_i + op_b_i;
  assign offset = addr[1:0];

  ////////////////////////////////////////
  // Split detection
  ////////////////////////////////////////

  // Word at any nonzero offset, halfword only when it crosses the word
  always_comb begin
    split_o = 1'b0;
    if (req_valid_i && !split_q) begin
      case (req_size_i)
        lsu_pkg::LSU_WORD: split_o = (offset != 2'b00);
        lsu_pkg::LSU_HALF: split_o = (offset == 2'b11);
        default:           split_o = 1'b0;
      endcase
    end
  end

  // Phase bit advances on each granted part
  // Dropped valid restarts the next access at its first part
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!req_valid_i) begin
      split_q <= 1'b0;
    end else if (txn_accept_i) begin
      split_q <= split_o;
    end
  end

  ////////////////////////////////////////
  // Address and lanes
  ////////////////////////////////////////

  // Second part goes to the next word, starting at lane 0
  assign addr_o = split_q ? ({addr[lsu_pkg::XLEN-1:2], 2'b00} + 32'd4) : addr;
  assign we_o   = req_we_i;

  always_comb begin
    case (req_size_i)
      lsu_pkg::LSU_BYTE: be_o = 4'b0001 << offset;
      // Upper lane only on the first part, lane 0 on the second
      lsu_pkg::LSU_HALF: be_o = split_q ? 4'b0001 : (4'b0011 << offset);
      // Low lanes left over from the first part
      lsu_pkg::LSU_WORD: be_o = split_q ? ~(4'b1111 << offset) : (4'b1111 << offset);
      default:           be_o = 4'b0000;
    endcase
  end

  // Rotate left by the offset so both parts see their bytes in lane
  assign wdata_dbl = {req_wdata_i, req_wdata_i} << {offset, 3'b000};
  assign wdata_o   = wdata_dbl[2*lsu_pkg::XLEN-1:lsu_pkg::XLEN];

  ////////////////////////////////////////
  // Control info for the response side
  ////////////////////////////////////////

  always_comb begin
    ctrl_o.size   = req_size_i;
    ctrl_o.sext   = req_sext_i;
    ctrl_o.we     = req_we_i;
    ctrl_o.offset = offset;
    // Only the first half of a split is not last
    ctrl_o.last   = !split_o;
  end

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
  parameter int MAX_OUTSTANDING = lsu_pkg::MAX_OUTSTANDING_DEF
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // Execute stage request
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  logic [lsu_pkg::XLEN-1:0] op_a_i,
  input  logic [lsu_pkg::XLEN-1:0] op_b_i,
  input  logic                     req_we_i,
  input  lsu_pkg::lsu_size_e       req_size_i,
  input  logic                     req_sext_i,
  input  logic [lsu_pkg::XLEN-1:0] req_wdata_i,

  // Data bus, address phase
  output logic                     data_req_o,
  input  logic                     data_gnt_i,
  output logic [lsu_pkg::XLEN-1:0] data_addr_o,
  output logic                     data_we_o,
  output logic [lsu_pkg::BE_W-1:0] data_be_o,
  output logic [lsu_pkg::XLEN-1:0] data_wdata_o,

  // Data bus, response phase
  input  logic                     data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] data_rdata_i,

  // Result to write-back
  output logic                     resp_valid_o,
  output logic [lsu_pkg::XLEN-1:0] resp_rdata_o
);

  // First part of a misaligned access in progress
  logic                split;
  // Transaction granted this cycle
  logic                txn_accept;
  // Control info of the transaction on the bus
  lsu_pkg::lsu_ctrl_t  req_ctrl;
  // Control info of the oldest outstanding transaction
  lsu_pkg::lsu_ctrl_t  head_ctrl;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  lsu_req_gen u_req_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .req_we_i     (req_we_i),
    .req_size_i   (req_size_i),
    .req_sext_i   (req_sext_i),
    .req_wdata_i  (req_wdata_i),
    .txn_accept_i (txn_accept),
    .split_o      (split),
    .addr_o       (data_addr_o),
    .we_o         (data_we_o),
    .be_o         (data_be_o),
    .wdata_o      (data_wdata_o),
    .ctrl_o       (req_ctrl)
  );

  lsu_txn_ctrl #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_txn_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .split_i       (split),
    .ctrl_i        (req_ctrl),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .txn_accept_o  (txn_accept),
    .req_ready_o   (req_ready_o),
    .head_ctrl_o   (head_ctrl)
  );

  ////////////////////////////////////////
  // Response phase
  ////////////////////////////////////////

  lsu_rdata_align u_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .rvalid_i     (data_rvalid_i),
    .rdata_i      (data_rdata_i),
    .ctrl_i       (head_ctrl),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o)
  );

endmodule

// ==== hw/lsu_txn_ctrl.sv ====
`timescale 1ns/1ps

module lsu_txn_ctrl #(
  parameter int MAX_OUTSTANDING = lsu_pkg::MAX_OUTSTANDING_DEF
) (
  input  logic               clk,
  input  logic               rst_n,

  // Current part from the request builder
  input  logic               req_valid_i,
  input  logic               split_i,
  input  lsu_pkg::lsu_ctrl_t ctrl_i,

  // Bus handshake
  output logic               data_req_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,

  // Grant pulse and upstream ready
  output logic               txn_accept_o,
  output logic               req_ready_o,

  // Oldest outstanding entry
  output lsu_pkg::lsu_ctrl_t head_ctrl_o
);

  // Counter must reach MAX_OUTSTANDING itself
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
  // At least one pointer bit, even for a single entry
  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  // Outstanding transactions
  logic [CNT_W-1:0]   cnt_q;
  logic [CNT_W-1:0]   cnt_n;
  logic               cnt_up;
  logic               cnt_down;

  // Control queue, one entry per granted transaction
  lsu_pkg::lsu_ctrl_t ctrl_mem [MAX_OUTSTANDING];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;

  ////////////////////////////////////////
  // Bus request and upstream ready
  ////////////////////////////////////////

  // No path from rvalid to req, a full counter waits one edge
  assign data_req_o   = req_valid_i && (cnt_q < CNT_W'(MAX_OUTSTANDING));
  assign txn_accept_o = data_req_o && data_gnt_i;

  // First half of a split keeps the execute stage waiting
  assign req_ready_o  = txn_accept_o && !split_i;

  ////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////

  assign cnt_up   = txn_accept_o;
  assign cnt_down = data_rvalid_i;

  always_comb begin
    case ({cnt_up, cnt_down})
      2'b10:   cnt_n = cnt_q + 1'b1;
      2'b01:   cnt_n = cnt_q - 1'b1;
      // Grant and read-valid together leave the count
      default: cnt_n = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  ////////////////////////////////////////
  // Control queue
  ////////////////////////////////////////

  // Pointers wrap at the configured depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (cnt_up) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (cnt_down) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Entry written at grant
  always_ff @(posedge clk) begin
    if (cnt_up) begin
      ctrl_mem[wr_ptr_q] <= ctrl_i;
    end
  end

  // Read-valid comes a cycle after grant at the earliest
  // so the head is always written before it is used
  assign head_ctrl_o = ctrl_mem[rd_ptr_q];

endmodule

// ==== vlog.f ====
hw/lsu_pkg.sv
hw/lsu_req_gen.sv
hw/lsu_txn_ctrl.sv
hw/lsu_rdata_align.sv
hw/lsu_top.sv
dv/lsu_properties.sv
dv/tb_lsu.sv
